/* Makefile */
SIM     = verilator
VFLAGS  = --binary --timing --assert
TOP     = tb_bpu_top
FLIST   = flist.f
OBJ_DIR = obj_dir
LOG     = sim.log

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST) tests/bpu_trace.txt
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
rtl/bpu_pkg.sv
rtl/bpu_dpsram.sv
rtl/bpu_ras.sv
rtl/bpu_pcgen.sv
rtl/bpu_top.sv
tests/bpu_properties.sv
tests/tb_bpu_top.sv

/* rtl/bpu_dpsram.sv */
module bpu_dpsram #(
  parameter int DATA_WIDTH = 30,
  parameter int DATA_DEPTH = 512
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // read port
  input  logic [$clog2(DATA_DEPTH)-1:0] raddr_i,
  input  logic                          ren_i,
  output logic [DATA_WIDTH-1:0]         rdata_o,
  // write port
  input  logic [$clog2(DATA_DEPTH)-1:0] waddr_i,
  input  logic                          we_i,
  input  logic [DATA_WIDTH-1:0]         wdata_i
);

  logic [DATA_WIDTH-1:0] mem [DATA_DEPTH];
  logic [DATA_WIDTH-1:0] rdata_q;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // same-edge collision returns the old word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (ren_i) begin
      rdata_q <= mem[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* rtl/bpu_pcgen.sv */
module bpu_pcgen #(
  parameter int BTB_DEPTH  = 512,
  parameter int INFO_DEPTH = 128
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  bpu_pkg::bpu_correct_t       correct_i,
  input  logic                        ready_i,
  output logic                        valid_o,
  output logic [31:0]                 pc_o,
  output logic [1:0]                  mask_o,
  output bpu_pkg::bpu_predict_t [1:0] predict_o,
  output bpu_pkg::bpu_ras_op_t        ras_op_o,
  input  logic [31:0]                 ras_top_i,
  input  logic [2:0]                  ras_ptr_i
);

  localparam int BTB_AW  = $clog2(BTB_DEPTH);
  localparam int INFO_AW = $clog2(INFO_DEPTH);

  typedef struct packed {
    bpu_pkg::bpu_target_e target_type;
    logic                 uncond;
    logic [4:0]           history;
    logic [6:0]           tag;
  } info_t;

  logic             fire;        // pc and read registers load
  logic [31:0]      pc_q;
  logic [31:0]      npc;
  logic             tid_q;
  logic             mask0_q;
  logic [1:0][31:0] btb_target;
  info_t [1:0]      info_q;
  info_t            info_wdata;
  logic [1:0]       cnt_q [32];
  logic [1:0][1:0]  cnt_rd;
  logic             cnt_we;
  logic [1:0]       cnt_wdata;
  logic [1:0]       slot_taken;
  logic [1:0]       take;
  logic             sel_slot;
  logic             any_take;
  bpu_pkg::bpu_target_e sel_type;

  // a redirect restarts fetch even under back-pressure
  assign fire = ready_i | correct_i.redirect;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tid_q <= 1'b0;
    end else if (correct_i.redirect) begin
      tid_q <= correct_i.tid;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q    <= bpu_pkg::BPU_RESET_PC;
      mask0_q <= ~bpu_pkg::BPU_RESET_PC[2];
    end else if (fire) begin
      pc_q    <= npc;
      mask0_q <= ~npc[2];  // odd word start drops slot 0
    end
  end

  assign pc_o = pc_q;

  always_comb begin
    info_wdata.target_type = correct_i.true_target_type;
    info_wdata.uncond      = correct_i.true_conditional_jmp;
    info_wdata.history     = {correct_i.history[3:0], correct_i.true_taken};
    info_wdata.tag         = correct_i.pc[16:10];
  end

  // second-level table of two-bit saturating counters
  assign cnt_we = correct_i.need_update && !correct_i.true_conditional_jmp &&
                  correct_i.true_target_type == bpu_pkg::BPU_TARGET_IMM;

  always_comb begin
    cnt_wdata = correct_i.lphr;
    if (correct_i.true_taken && correct_i.lphr != 2'b11) begin
      cnt_wdata = correct_i.lphr + 2'd1;
    end else if (!correct_i.true_taken && correct_i.lphr != 2'b00) begin
      cnt_wdata = correct_i.lphr - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        cnt_q[i] <= 2'b00;
      end
    end else if (cnt_we) begin
      cnt_q[correct_i.history] <= cnt_wdata;
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_slot
    logic                  btb_we;
    logic                  info_we;
    logic [INFO_AW-1:0]    info_raddr;
    logic [INFO_AW-1:0]    info_waddr;
    info_t                 info_ram [INFO_DEPTH];
    logic [INFO_DEPTH-1:0] info_vld;
    info_t                 info_rd_q;
    logic                  vld_rd_q;
    logic                  tag_hit;
    logic                  use_cnt;

    assign btb_we = correct_i.need_update && correct_i.pc[2] == 1'(p) &&
                    (correct_i.true_target_type == bpu_pkg::BPU_TARGET_CALL ||
                     correct_i.true_target_type == bpu_pkg::BPU_TARGET_IMM);

    bpu_dpsram #(
      .DATA_WIDTH(30),
      .DATA_DEPTH(BTB_DEPTH)
    ) btb_ram (
      .clk     (clk),
      .rst_n   (rst_n),
      .raddr_i (npc[BTB_AW+2:3]),
      .ren_i   (fire),
      .rdata_o (btb_target[p][31:2]),
      .waddr_i (correct_i.pc[BTB_AW+2:3]),
      .we_i    (btb_we),
      .wdata_i (correct_i.btb_target[31:2])
    );
    assign btb_target[p][1:0] = 2'b00;

    assign info_we    = correct_i.need_update && correct_i.pc[2] == 1'(p);
    assign info_raddr = npc[INFO_AW+2:3];
    assign info_waddr = correct_i.pc[INFO_AW+2:3];

    always_ff @(posedge clk) begin
      if (info_we) begin
        info_ram[info_waddr] <= info_wdata;
      end
    end

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        info_vld <= '0;
      end else if (info_we) begin
        info_vld[info_waddr] <= 1'b1;
      end
    end

    // read data lines up with the block fetched next cycle
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        vld_rd_q <= 1'b0;
      end else if (fire) begin
        vld_rd_q <= info_vld[info_raddr];
      end
    end

    always_ff @(posedge clk) begin
      if (fire) begin
        info_rd_q <= info_ram[info_raddr];
      end
    end

    assign info_q[p] = info_rd_q;
    assign cnt_rd[p] = cnt_q[info_rd_q.history];

    assign tag_hit = vld_rd_q && info_rd_q.tag == pc_q[16:10] &&
                     info_rd_q.target_type != bpu_pkg::BPU_TARGET_NPC;
    assign use_cnt = info_rd_q.target_type == bpu_pkg::BPU_TARGET_IMM && !info_rd_q.uncond;
    assign slot_taken[p] = tag_hit && (use_cnt ? cnt_rd[p][1] : 1'b1);
  end

  // slot 0 has priority when it is inside the block
  assign take[0]  = mask0_q & slot_taken[0];
  assign take[1]  = ~take[0] & slot_taken[1];
  assign any_take = |take;
  assign sel_slot = take[1];
  assign sel_type = info_q[sel_slot].target_type;

  always_comb begin
    npc = {pc_q[31:3] + 29'd1, 3'b000};  // sequential block
    if (correct_i.redirect) begin
      npc = correct_i.true_target;
    end else if (any_take) begin
      npc = (sel_type == bpu_pkg::BPU_TARGET_RETURN) ? ras_top_i : btb_target[sel_slot];
    end
  end

  assign valid_o = ~correct_i.redirect;
  assign mask_o  = {~take[0], mask0_q};

  // no stack op for a block that is discarded
  assign ras_op_o.push = any_take && !correct_i.redirect &&
                         sel_type == bpu_pkg::BPU_TARGET_CALL;
  assign ras_op_o.pop  = any_take && !correct_i.redirect &&
                         sel_type == bpu_pkg::BPU_TARGET_RETURN;
  assign ras_op_o.push_addr = {pc_q[31:3], 3'b000} + (take[0] ? 32'd4 : 32'd8);

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      predict_o[i].taken       = take[i];
      predict_o[i].tid         = tid_q;
      predict_o[i].predict_pc  = npc;
      predict_o[i].lphr        = cnt_rd[i];
      predict_o[i].history     = info_q[i].history;
      predict_o[i].target_type = info_q[i].target_type;
      predict_o[i].dir_type    = info_q[i].uncond;
      predict_o[i].ras_ptr     = ras_ptr_i;
    end
  end

endmodule

/* rtl/bpu_pkg.sv */
package bpu_pkg;

  // branch kind as stored in the info tables
  typedef enum logic [1:0] {
    BPU_TARGET_NPC    = 2'd0,  // not a branch
    BPU_TARGET_CALL   = 2'd1,
    BPU_TARGET_RETURN = 2'd2,
    BPU_TARGET_IMM    = 2'd3   // direct jump or conditional branch
  } bpu_target_e;

  // per-slot prediction, travels with the fetch block
  typedef struct packed {
    logic        taken;
    logic        tid;
    logic [31:0] predict_pc;
    logic [1:0]  lphr;         // counter value read
    logic [4:0]  history;
    bpu_target_e target_type;
    logic        dir_type;     // set for unconditional
    logic [2:0]  ras_ptr;
  } bpu_predict_t;

  // correction bundle from the backend, single cycle
  typedef struct packed {
    logic        redirect;
    logic        need_update;
    logic        miss;
    logic        ras_miss_type;
    logic        tid;
    logic [31:0] pc;
    logic [31:0] true_target;
    logic [31:0] btb_target;
    bpu_target_e true_target_type;
    logic        true_conditional_jmp;  // set for unconditional
    logic        true_taken;
    logic [4:0]  history;
    logic [1:0]  lphr;
    logic [2:0]  ras_ptr;
  } bpu_correct_t;

  typedef struct packed {
    logic        push;
    logic        pop;
    logic [31:0] push_addr;
  } bpu_ras_op_t;

  localparam logic [31:0] BPU_RESET_PC = 32'h1c00_0000;

endpackage

/* rtl/bpu_ras.sv */
module bpu_ras #(
  parameter int RAS_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  bpu_pkg::bpu_ras_op_t  op_i,
  input  logic                  advance_i,
  input  bpu_pkg::bpu_correct_t correct_i,
  output logic [31:0]           top_o,
  output logic [2:0]            ptr_o
);

  localparam int PTR_W = $clog2(RAS_DEPTH);

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] fix_ptr;
  logic [31:0]      stack_q [RAS_DEPTH];
  logic [31:0]      top_q;
  logic             repair;
  logic             fix_call;

  assign repair   = correct_i.miss | correct_i.ras_miss_type;
  assign fix_ptr  = PTR_W'(correct_i.ras_ptr);
  assign fix_call = correct_i.true_target_type == bpu_pkg::BPU_TARGET_CALL;

  // pointer update, repair beats speculation
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= PTR_W'(1);
    end else if (repair) begin
      rd_ptr_q <= fix_ptr;
      wr_ptr_q <= fix_ptr + PTR_W'(1);
    end else if (advance_i && op_i.push) begin
      rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      wr_ptr_q <= wr_ptr_q + PTR_W'(1);
    end else if (advance_i && op_i.pop) begin
      rd_ptr_q <= rd_ptr_q - PTR_W'(1);
      wr_ptr_q <= wr_ptr_q - PTR_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (repair) begin
      if (fix_call) begin
        stack_q[fix_ptr] <= correct_i.pc + 32'd4;  // return address of the call
      end
    end else if (advance_i && op_i.push) begin
      stack_q[wr_ptr_q] <= op_i.push_addr;
    end
  end

  // top is one cycle behind the pointer
  always_ff @(posedge clk) begin
    top_q <= stack_q[rd_ptr_q];
  end

  assign top_o = top_q;
  assign ptr_o = 3'(rd_ptr_q);

endmodule

/* rtl/bpu_top.sv */
module bpu_top #(
  parameter int BTB_DEPTH  = 512,
  parameter int INFO_DEPTH = 128,
  parameter int RAS_DEPTH  = 8
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  bpu_pkg::bpu_correct_t       p_correct_i,
  input  logic                        p_ready_i,
  output logic                        p_valid_o,
  output logic [31:0]                 p_pc_o,
  output logic [1:0]                  p_mask_o,
  output bpu_pkg::bpu_predict_t [1:0] p_predict_o
);

  bpu_pkg::bpu_ras_op_t ras_op;
  logic [31:0]          ras_top;
  logic [2:0]           ras_ptr;

  bpu_pcgen #(
    .BTB_DEPTH  (BTB_DEPTH),
    .INFO_DEPTH (INFO_DEPTH)
  ) pcgen (
    .clk       (clk),
    .rst_n     (rst_n),
    .correct_i (p_correct_i),
    .ready_i   (p_ready_i),
    .valid_o   (p_valid_o),
    .pc_o      (p_pc_o),
    .mask_o    (p_mask_o),
    .predict_o (p_predict_o),
    .ras_op_o  (ras_op),
    .ras_top_i (ras_top),
    .ras_ptr_i (ras_ptr)
  );

  bpu_ras #(
    .RAS_DEPTH (RAS_DEPTH)
  ) ras (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_i      (ras_op),
    .advance_i (p_ready_i),  // no push or pop under back-pressure
    .correct_i (p_correct_i),
    .top_o     (ras_top),
    .ptr_o     (ras_ptr)
  );

endmodule

/* tests/bpu_properties.sv */
module bpu_properties (
  input logic                        clk,
  input logic                        rst_n,
  input logic                        p_ready_i,
  input bpu_pkg::bpu_correct_t       p_correct_i,
  input logic                        p_valid_o,
  input logic [31:0]                 p_pc_o,
  input bpu_pkg::bpu_predict_t [1:0] p_predict_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // first cycle out of reset fetches from the reset vector
  a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> p_pc_o == bpu_pkg::BPU_RESET_PC)
    else $error("fetch PC after reset is %h", p_pc_o);

  a_hold_pc: assert property (@(posedge clk) disable iff (!rst_n)
    (!p_ready_i && !p_correct_i.redirect) |=> $stable(p_pc_o))
    else $error("fetch PC moved under back-pressure");

  a_valid: assert property (@(posedge clk) disable iff (!rst_n)
    p_valid_o == !p_correct_i.redirect)
    else $error("valid does not follow the redirect strobe");

  a_one_taken: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({p_predict_o[1].taken, p_predict_o[0].taken}))
    else $error("both slots predict taken");

endmodule

bind bpu_top bpu_properties props_inst (
  .clk         (clk),
  .rst_n       (rst_n),
  .p_ready_i   (p_ready_i),
  .p_correct_i (p_correct_i),
  .p_valid_o   (p_valid_o),
  .p_pc_o      (p_pc_o),
  .p_predict_o (p_predict_o)
);

/* tests/bpu_trace.txt */
# rdy redirect upd miss rasmiss tid pc true_target btb_target type uncond taken hist lphr rasptr
# then: check valid pc mask taken0 taken1 (all hex, type 0 npc 1 call 2 return 3 imm)
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1c000000 3 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1c000008 3 0 0
1 0 1 0 0 0 1c000200 0 1c000400 3 1 1 0 0 0 1 1 1c000008 3 0 0
1 1 0 0 0 0 0 1c000104 0 0 0 0 0 0 0 1 0 1c000010 3 0 0
1 0 1 0 0 0 1c000604 0 1c000800 3 0 1 1f 0 0 1 1 1c000104 2 0 0
1 1 0 0 0 0 0 1c000200 0 0 0 0 0 0 0 1 0 1c000108 3 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1c000200 1 1 0
1 1 0 0 0 0 0 1c000600 0 0 0 0 0 0 0 1 0 1c000400 3 0 0
1 0 1 0 0 0 1c000604 0 1c000800 3 0 1 1f 1 0 1 1 1c000600 3 0 0
1 1 0 0 0 0 0 1c000600 0 0 0 0 0 0 0 1 0 1c000608 3 0 0
1 0 1 0 0 0 1c000a0c 0 1c000c00 3 0 0 1f 2 0 1 1 1c000600 3 0 1
1 1 1 0 0 0 1c000a0c 1c000600 1c000c00 3 0 0 1f 1 0 1 0 1c000800 3 0 0
1 0 1 0 0 0 1c001004 0 1c002000 1 1 1 0 0 0 1 1 1c000600 3 0 0
1 1 1 0 0 0 1c002000 1c001000 0 2 1 1 0 0 0 1 0 1c000608 3 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1c001000 3 0 1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1c002000 1 1 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1c002000 1 1 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1c001008 3 0 0

/* tests/tb_bpu_top.sv */
module tb_bpu_top;
  timeunit 1ns;
  timeprecision 100ps;

  logic                        clk;
  logic                        rst_n;
  logic                        p_ready_i;
  bpu_pkg::bpu_correct_t       p_correct_i;
  logic                        p_valid_o;
  logic [31:0]                 p_pc_o;
  logic [1:0]                  p_mask_o;
  bpu_pkg::bpu_predict_t [1:0] p_predict_o;
  int                          errors;
  int                          checks;

  bpu_top bpu_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .p_correct_i (p_correct_i),
    .p_ready_i   (p_ready_i),
    .p_valid_o   (p_valid_o),
    .p_pc_o      (p_pc_o),
    .p_mask_o    (p_mask_o),
    .p_predict_o (p_predict_o)
  );

  always #50 clk = ~clk;

  task automatic compare_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  initial begin
    string       line;
    int          fd;
    int          n;
    int          cycles;
    int          wait_cnt;
    logic [31:0] v [21];

    clk         = 1'b0;
    rst_n       = 1'b0;
    p_ready_i   = 1'b0;
    p_correct_i = '0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    fd = $fopen("tests/bpu_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the trace file tests/bpu_trace.txt");
    end
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    wait_cnt = 0;
    while (p_valid_o !== 1'b1 && wait_cnt < 10) begin  // fetch comes up valid
      @(posedge clk);
      #1 wait_cnt++;
    end
    if (wait_cnt >= 10) begin
      errors++;
      $display("fetch never became valid after reset");
    end
    while (fd != 0 && !$feof(fd) && cycles < 200) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                    v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20]);
        if (n != 21) begin
          errors++;
          $display("malformed trace line: %s", line);
        end else begin
          p_ready_i                        = v[0][0];
          p_correct_i.redirect             = v[1][0];
          p_correct_i.need_update          = v[2][0];
          p_correct_i.miss                 = v[3][0];
          p_correct_i.ras_miss_type        = v[4][0];
          p_correct_i.tid                  = v[5][0];
          p_correct_i.pc                   = v[6];
          p_correct_i.true_target          = v[7];
          p_correct_i.btb_target           = v[8];
          p_correct_i.true_target_type     = bpu_pkg::bpu_target_e'(v[9][1:0]);
          p_correct_i.true_conditional_jmp = v[10][0];
          p_correct_i.true_taken           = v[11][0];
          p_correct_i.history              = v[12][4:0];
          p_correct_i.lphr                 = v[13][1:0];
          p_correct_i.ras_ptr              = v[14][2:0];
          #97;  // sample just before the next edge
          if (v[15][0]) begin
            compare_value("p_valid_o", 32'(p_valid_o), v[16]);
            compare_value("p_pc_o", p_pc_o, v[17]);
            compare_value("p_mask_o", 32'(p_mask_o), v[18]);
            compare_value("slot 0 taken", 32'(p_predict_o[0].taken), v[19]);
            compare_value("slot 1 taken", 32'(p_predict_o[1].taken), v[20]);
          end
          @(posedge clk);
          #1 cycles++;
        end
      end
    end
    if (cycles >= 200) begin
      errors++;
      $display("trace did not finish within 200 cycles");
    end else if (cycles == 0) begin
      errors++;
      $display("trace held no cycles to run");
    end
    if (fd != 0) $fclose(fd);
    $display("cycles %0d, checks %0d, errors %0d", cycles, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
